// ==== source/ltsm_pkg.sv ====
package ltsm_pkg;

    // Link training states
    // Code 6 has no state and decodes as RESET
    typedef enum logic [2:0] {
        RESET      = 3'd0,
        SBINIT     = 3'd1,
        MBINIT     = 3'd2,
        MBTRAIN    = 3'd3,
        LINKINIT   = 3'd4,
        ACTIVE     = 3'd5,
        TRAINERROR = 3'd7
    } ltsm_state_t;

    // Sideband message kinds
    typedef enum logic [3:0] {
        OP_REQ = 4'd1,
        OP_RSP = 4'd2,
        OP_ERR = 4'd15
    } sb_opcode_t;

    // Opcode in the upper bits so the packed value matches frame bits 6 to 0
    typedef struct packed {
        sb_opcode_t  opcode;
        ltsm_state_t phase;
    } sb_msg_t;

    // Serial frame length
    // Bits 2:0 phase, bits 6:3 opcode, bit 7 even parity over bits 6:0
    localparam int SB_FRAME_W = 8;

endpackage

// ==== source/sb_msg_if.sv ====
`timescale 1ns/10ps

// One sideband message moved with a four-phase req/ack handshake
interface sb_msg_if import ltsm_pkg::*; ();

    logic        req;
    logic        ack;
    sb_opcode_t  opcode;
    ltsm_state_t phase;

    // Source holds opcode and phase stable while req is high
    modport source (
        output req,
        output opcode,
        output phase,
        input  ack
    );

    modport sink (
        input  req,
        input  opcode,
        input  phase,
        output ack
    );

endinterface

// ==== source/sb_frame_tx.sv ====
`timescale 1ns/10ps

module sb_frame_tx import ltsm_pkg::*; (
    input  logic   clk_100MHz,
    input  logic   reset,
    sb_msg_if.sink msg,
    output logic   sb_clk_o,
    output logic   sb_data_o
);

    localparam int CNT_W = $clog2(SB_FRAME_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SB_FRAME_W - 1);

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_SHIFT = 2'd1,
        TX_ACK   = 2'd2
    } tx_state_t;

    tx_state_t             tx_state;
    sb_msg_t               msg_w;
    logic [SB_FRAME_W-1:0] frame_w;
    logic [SB_FRAME_W-2:0] shift_q;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  start;
    logic                  clk_q;
    logic                  data_q;
    logic                  ack_q;

    // Parity bit on top makes the whole frame even
    assign msg_w   = '{opcode: msg.opcode, phase: msg.phase};
    assign frame_w = {^msg_w, msg_w};
    assign start   = (tx_state == TX_IDLE) && msg.req;

    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            tx_state <= TX_IDLE;
            bit_cnt  <= '0;
            clk_q    <= 1'b0;
            data_q   <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            case (tx_state)
                TX_IDLE: begin
                    // Bit 0 goes out together with the first strobe
                    if (start) begin
                        tx_state <= TX_SHIFT;
                        bit_cnt  <= '0;
                        clk_q    <= 1'b1;
                        data_q   <= frame_w[0];
                    end
                end
                TX_SHIFT: begin
                    if (bit_cnt == LAST_BIT) begin
                        tx_state <= TX_ACK;
                        clk_q    <= 1'b0;
                        data_q   <= 1'b0;
                        ack_q    <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        data_q  <= shift_q[0];
                    end
                end
                TX_ACK: begin
                    // Hold ack until the source lets go of req
                    if (!msg.req) begin
                        tx_state <= TX_IDLE;
                        ack_q    <= 1'b0;
                    end
                end
                default: begin
                    tx_state <= TX_IDLE;
                end
            endcase
        end
    end

    // Remaining bits, next one always in bit 0
    always_ff @(posedge clk_100MHz) begin
        if (start) begin
            shift_q <= frame_w[SB_FRAME_W-1:1];
        end else if (tx_state == TX_SHIFT) begin
            shift_q <= shift_q >> 1;
        end
    end

    assign msg.ack   = ack_q;
    assign sb_clk_o  = clk_q;
    assign sb_data_o = data_q;

endmodule

// ==== source/sb_frame_rx.sv ====
`timescale 1ns/10ps

module sb_frame_rx import ltsm_pkg::*; (
    input  logic     clk_100MHz,
    input  logic     reset,
    input  logic     sb_clk_i,
    input  logic     sb_data_i,
    sb_msg_if.source msg
);

    localparam int CNT_W = $clog2(SB_FRAME_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SB_FRAME_W - 1);

    logic [CNT_W-1:0]      bit_cnt;
    logic [SB_FRAME_W-2:0] shift_q;
    logic [SB_FRAME_W-1:0] frame_w;
    logic                  frame_end;
    logic                  parity_ok;
    logic                  accept;
    logic                  req_q;
    sb_msg_t               msg_q;

    // Full frame is visible while its last bit is on the pin
    assign frame_w   = {sb_data_i, shift_q};
    assign frame_end = sb_clk_i && (bit_cnt == LAST_BIT);
    assign parity_ok = ~^frame_w;

    // Drop the frame if the previous message is still in its handshake
    assign accept = frame_end && parity_ok && !req_q && !msg.ack;

    // Idle strobe cycles bring the counter back to bit 0
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            bit_cnt <= '0;
        end else if (!sb_clk_i || frame_end) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // LSB first, so new bits enter at the top
    always_ff @(posedge clk_100MHz) begin
        if (sb_clk_i) begin
            shift_q <= {sb_data_i, shift_q[SB_FRAME_W-2:1]};
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (accept) begin
            msg_q <= sb_msg_t'(frame_w[SB_FRAME_W-2:0]);
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            req_q <= 1'b0;
        end else if (accept) begin
            req_q <= 1'b1;
        end else if (req_q && msg.ack) begin
            req_q <= 1'b0;
        end
    end

    assign msg.req    = req_q;
    assign msg.opcode = msg_q.opcode;
    assign msg.phase  = msg_q.phase;

endmodule

// ==== source/ltsm_timers.sv ====
`timescale 1ns/10ps

module ltsm_timers import ltsm_pkg::*; #(
    parameter int RESET_DWELL_CYCLES = 100,
    parameter int RETRY_CYCLES       = 100,
    parameter int TIMEOUT_CYCLES     = 800000
) (
    input  logic        clk_100MHz,
    input  logic        reset,
    input  ltsm_state_t state_i,
    input  logic        retry_restart_i,
    output logic        dwell_done_o,
    output logic        retry_expired_o,
    output logic        timeout_o
);

    localparam int DWELL_W   = $clog2(RESET_DWELL_CYCLES + 1);
    localparam int RETRY_W   = $clog2(RETRY_CYCLES + 1);
    localparam int TIMEOUT_W = $clog2(TIMEOUT_CYCLES + 1);

    localparam logic [DWELL_W-1:0]   DWELL_END   = DWELL_W'(RESET_DWELL_CYCLES);
    localparam logic [RETRY_W-1:0]   RETRY_END   = RETRY_W'(RETRY_CYCLES);
    localparam logic [TIMEOUT_W-1:0] TIMEOUT_END = TIMEOUT_W'(TIMEOUT_CYCLES);

    logic [DWELL_W-1:0]   dwell_cnt;
    logic [RETRY_W-1:0]   retry_cnt;
    logic [TIMEOUT_W-1:0] timeout_cnt;
    ltsm_state_t          prev_state_q;
    logic                 state_change;
    logic                 in_phase;

    assign state_change = (state_i != prev_state_q);
    assign in_phase     = state_i inside {SBINIT, MBINIT, MBTRAIN, LINKINIT};

    // All three counters saturate at their end value
    assign dwell_done_o    = (dwell_cnt == DWELL_END);
    assign retry_expired_o = (retry_cnt == RETRY_END);
    assign timeout_o       = (timeout_cnt == TIMEOUT_END);

    // Minimum time spent in RESET
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            dwell_cnt <= '0;
        end else if (state_i != RESET) begin
            dwell_cnt <= '0;
        end else if (!dwell_done_o) begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // Time in one training phase, cleared on any state change
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            prev_state_q <= RESET;
            timeout_cnt  <= '0;
        end else begin
            prev_state_q <= state_i;
            if (state_change || !in_phase) begin
                timeout_cnt <= '0;
            end else if (!timeout_o) begin
                timeout_cnt <= timeout_cnt + 1'b1;
            end
        end
    end

    // Window for the partner to answer a request
    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            retry_cnt <= '0;
        end else if (retry_restart_i) begin
            retry_cnt <= '0;
        end else if (!retry_expired_o) begin
            retry_cnt <= retry_cnt + 1'b1;
        end
    end

endmodule

// ==== source/ltsm_sequencer.sv ====
`timescale 1ns/10ps

module ltsm_sequencer import ltsm_pkg::*; (
    input  logic        clk_100MHz,
    input  logic        reset,
    input  logic        enable_i,
    input  logic        start_lt_i,
    input  logic        dwell_done_i,
    input  logic        retry_expired_i,
    input  logic        timeout_i,
    output logic        retry_restart_o,
    sb_msg_if.source    tx,
    sb_msg_if.sink      rx,
    output ltsm_state_t state_o,
    output logic        link_active_o
);

    ltsm_state_t state_q;
    ltsm_state_t state_d;
    ltsm_state_t tx_phase_q;
    sb_opcode_t  tx_opcode_q;
    logic        in_phase;
    logic        tx_req_q;
    logic        tx_busy;
    logic        sent_q;
    logic        launch;
    logic        rx_ack_q;
    logic        rx_take;
    logic        rsp_match;

    assign in_phase = state_q inside {SBINIT, MBINIT, MBTRAIN, LINKINIT};
    assign tx_busy  = tx_req_q || tx.ack;

    // Received message is valid in the cycle our ack is up
    assign rx_take   = rx.req && rx_ack_q;
    assign rsp_match = rx_take && (rx.opcode == OP_RSP) && (rx.phase == state_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            RESET: begin
                if (enable_i && start_lt_i && dwell_done_i) begin
                    state_d = SBINIT;
                end
            end
            SBINIT, MBINIT, MBTRAIN, LINKINIT: begin
                if (timeout_i) begin
                    state_d = TRAINERROR;
                end else if (rsp_match) begin
                    case (state_q)
                        SBINIT:  state_d = MBINIT;
                        MBINIT:  state_d = MBTRAIN;
                        MBTRAIN: state_d = LINKINIT;
                        default: state_d = ACTIVE;
                    endcase
                end
            end
            ACTIVE: begin
                state_d = ACTIVE;
            end
            TRAINERROR: begin
                // Error frame sent and its handshake closed
                if (sent_q && !tx_busy) begin
                    state_d = RESET;
                end
            end
            default: begin
                state_d = RESET;
            end
        endcase
    end

    // New request on phase entry, resend on retry expiry, one error frame
    always_comb begin
        launch = 1'b0;
        if (!tx_busy && (state_d == state_q)) begin
            if (in_phase) begin
                launch = !sent_q || retry_expired_i;
            end else if (state_q == TRAINERROR) begin
                launch = !sent_q;
            end
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (reset) begin
            state_q  <= RESET;
            tx_req_q <= 1'b0;
            sent_q   <= 1'b0;
            rx_ack_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Every received message is consumed, matching or not
            rx_ack_q <= rx.req;
            if (launch) begin
                tx_req_q <= 1'b1;
            end else if (tx.ack) begin
                tx_req_q <= 1'b0;
            end
            if (state_d != state_q) begin
                sent_q <= 1'b0;
            end else if (launch) begin
                sent_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100MHz) begin
        if (launch) begin
            tx_opcode_q <= (state_q == TRAINERROR) ? OP_ERR : OP_REQ;
            tx_phase_q  <= state_q;
        end
    end

    assign retry_restart_o = launch;
    assign tx.req          = tx_req_q;
    assign tx.opcode       = tx_opcode_q;
    assign tx.phase        = tx_phase_q;
    assign rx.ack          = rx_ack_q;
    assign state_o         = state_q;
    assign link_active_o   = (state_q == ACTIVE);

endmodule

// ==== source/ltsm_top.sv ====
`timescale 1ns/10ps

module ltsm_top import ltsm_pkg::*; #(
    parameter int RESET_DWELL_CYCLES = 100,
    parameter int RETRY_CYCLES       = 100,
    parameter int TIMEOUT_CYCLES     = 800000
) (
    input  logic        clk_100MHz,
    input  logic        reset,
    input  logic        enable_i,
    input  logic        start_lt_i,
    input  logic        sb_clk_i,
    input  logic        sb_data_i,
    output logic        sb_clk_o,
    output logic        sb_data_o,
    output ltsm_state_t ltsm_state_o,
    output logic        link_active_o
);

    ltsm_state_t state;
    logic        retry_restart;
    logic        dwell_done;
    logic        retry_expired;
    logic        timeout;

    // Messages to and from the link partner
    sb_msg_if tx_msg ();
    sb_msg_if rx_msg ();

    sb_frame_rx sb_frame_rx_i (
        .clk_100MHz (clk_100MHz),
        .reset      (reset),
        .sb_clk_i   (sb_clk_i),
        .sb_data_i  (sb_data_i),
        .msg        (rx_msg.source)
    );

    ltsm_timers #(
        .RESET_DWELL_CYCLES (RESET_DWELL_CYCLES),
        .RETRY_CYCLES       (RETRY_CYCLES),
        .TIMEOUT_CYCLES     (TIMEOUT_CYCLES)
    ) ltsm_timers_i (
        .clk_100MHz      (clk_100MHz),
        .reset           (reset),
        .state_i         (state),
        .retry_restart_i (retry_restart),
        .dwell_done_o    (dwell_done),
        .retry_expired_o (retry_expired),
        .timeout_o       (timeout)
    );

    ltsm_sequencer ltsm_sequencer_i (
        .clk_100MHz      (clk_100MHz),
        .reset           (reset),
        .enable_i        (enable_i),
        .start_lt_i      (start_lt_i),
        .dwell_done_i    (dwell_done),
        .retry_expired_i (retry_expired),
        .timeout_i       (timeout),
        .retry_restart_o (retry_restart),
        .tx              (tx_msg.source),
        .rx              (rx_msg.sink),
        .state_o         (state),
        .link_active_o   (link_active_o)
    );

    sb_frame_tx sb_frame_tx_i (
        .clk_100MHz (clk_100MHz),
        .reset      (reset),
        .msg        (tx_msg.sink),
        .sb_clk_o   (sb_clk_o),
        .sb_data_o  (sb_data_o)
    );

    assign ltsm_state_o = state;

endmodule

// ==== verification/sb_partner_model.svh ====
// Link partner model, included inside ltsm_tb

// Frame layout: phase in bits 2:0, opcode in 6:3, even parity in bit 7
function automatic logic [7:0] make_frame(input sb_opcode_t op, input ltsm_state_t ph);
    logic [6:0] body;
    body = {op, ph};
    return {^body, body};
endfunction

// Drive one frame LSB first under the strobe, then leave the pins idle
task automatic send_frame(input logic [7:0] frame);
    int k;
    for (k = 0; k < SB_FRAME_W; k++) begin
        @(posedge clk_100MHz);
        #1;
        sb_clk_i  = 1'b1;
        sb_data_i = frame[k];
    end
    @(posedge clk_100MHz);
    #1;
    sb_clk_i  = 1'b0;
    sb_data_i = 1'b0;
    // Gap long enough for the DUT receiver to finish its handshake
    repeat (6) @(posedge clk_100MHz);
    #1;
endtask

// Collects every DUT frame bit by bit into rx_frames
task automatic decode_frames();
    logic [7:0] shift;
    int         nbits;
    logic       ended;
    shift = '0;
    nbits = 0;
    ended = 1'b0;
    forever begin
        @(negedge clk_100MHz);
        if (sb_clk_o) begin
            assert (!ended) else begin
                $display("DUT frame at %0t follows the previous one with no idle cycle", $time);
                error_count++;
            end
            shift[nbits] = sb_data_o;
            nbits++;
            ended = 1'b0;
            if (nbits == SB_FRAME_W) begin
                check_value("sb_data_o parity", {31'd0, ^shift}, 0);
                rx_frames.push_back(shift);
                nbits = 0;
                ended = 1'b1;
            end
        end else begin
            assert (nbits == 0) else begin
                $display("DUT strobe dropped after %0d bits at %0t", nbits, $time);
                error_count++;
            end
            nbits = 0;
            ended = 1'b0;
        end
    end
endtask

task automatic wait_frame(output logic [7:0] frame, output logic found);
    int i;
    frame = '0;
    found = 1'b0;
    for (i = 0; i < FRAME_WAIT && !found; i++) begin
        if (rx_frames.size() > 0) begin
            frame = rx_frames.pop_front();
            found = 1'b1;
        end else begin
            @(posedge clk_100MHz);
            #1;
        end
    end
    assert (found) else begin
        $display("Timeout: no frame from the DUT within %0d cycles", FRAME_WAIT);
        error_count++;
    end
endtask

// Resends of the previous request may still be queued ahead of the expected frame
task automatic expect_frame(input logic [7:0] exp, input logic [7:0] skip);
    logic [7:0] frame;
    logic       found;
    int         n;
    for (n = 0; n < 64; n++) begin
        wait_frame(frame, found);
        if (!found || frame !== skip) begin
            break;
        end
    end
    if (found) begin
        check_value("sb_frame", {24'd0, frame}, {24'd0, exp});
    end
endtask

// ==== verification/ltsm_tb.sv ====
`timescale 1ns/10ps

module ltsm_tb import ltsm_pkg::*; ();

    localparam int RESET_DWELL_CYCLES = 100;
    localparam int RETRY_CYCLES       = 100;
    localparam int TIMEOUT_CYCLES     = 3000;
    localparam int FRAME_WAIT         = 500;

    logic        clk_100MHz;
    logic        reset;
    logic        enable_i;
    logic        start_lt_i;
    logic        sb_clk_i;
    logic        sb_data_i;
    logic        sb_clk_o;
    logic        sb_data_o;
    logic        link_active_o;
    ltsm_state_t ltsm_state_o;

    logic [7:0]  rx_frames[$];
    logic [31:0] lcg_state    = 32'd21459;
    int          error_count  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    ltsm_top #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) dut_i (
        .clk_100MHz    (clk_100MHz),
        .reset         (reset),
        .enable_i      (enable_i),
        .start_lt_i    (start_lt_i),
        .sb_clk_i      (sb_clk_i),
        .sb_data_i     (sb_data_i),
        .sb_clk_o      (sb_clk_o),
        .sb_data_o     (sb_data_o),
        .ltsm_state_o  (ltsm_state_o),
        .link_active_o (link_active_o)
    );

    initial begin
        clk_100MHz = 1'b0;
        forever #5 clk_100MHz = ~clk_100MHz;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[30:15]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            error_count++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, error_count - errs_before);
        end
    endtask

    `include "sb_partner_model.svh"

    // Expected order of the training phases
    function automatic ltsm_state_t next_phase(input ltsm_state_t ph);
        case (ph)
            SBINIT:   return MBINIT;
            MBINIT:   return MBTRAIN;
            MBTRAIN:  return LINKINIT;
            LINKINIT: return ACTIVE;
            default:  return RESET;
        endcase
    endfunction

    task automatic wait_state(input ltsm_state_t target, input int limit);
        int i;
        for (i = 0; i < limit && ltsm_state_o != target; i++) begin
            @(posedge clk_100MHz);
            #1;
        end
        check_value("ltsm_state_o", ltsm_state_o, target);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) @(posedge clk_100MHz);
        #1;
        reset = 1'b0;
        rx_frames.delete();
    endtask

    task automatic start_training();
        start_lt_i = 1'b1;
        wait_state(SBINIT, RESET_DWELL_CYCLES + 20);
        start_lt_i = 1'b0;
    endtask

    // One request/response exchange, answered after delay cycles
    task automatic train_phase(input ltsm_state_t ph, input ltsm_state_t prev, input int delay);
        logic [7:0] req_f;
        int         resends;
        req_f = make_frame(OP_REQ, ph);
        expect_frame(req_f, make_frame(OP_REQ, prev));
        check_value("ltsm_state_o", ltsm_state_o, ph);
        check_value("link_active_o", link_active_o, 0);
        repeat (delay) @(posedge clk_100MHz);
        #1;
        resends = 0;
        while (rx_frames.size() > 0) begin
            check_value("sb_frame", {24'd0, rx_frames.pop_front()}, {24'd0, req_f});
            resends++;
        end
        // Margin covers the frame length after the retry window
        if (delay > RETRY_CYCLES + 12) begin
            assert (resends > 0) else begin
                $display("No resend of the %s request within %0d cycles", ph.name(), delay);
                error_count++;
            end
        end else if (delay < RETRY_CYCLES) begin
            assert (resends == 0) else begin
                $display("%0d resends of the %s request before the retry window ended",
                         resends, ph.name());
                error_count++;
            end
        end
        check_value("ltsm_state_o", ltsm_state_o, ph);
        send_frame(make_frame(OP_RSP, ph));
        wait_state(next_phase(ph), 30);
    endtask

    task automatic train_link();
        ltsm_state_t ph;
        ltsm_state_t prev;
        int          delay;
        prev = RESET;
        ph   = SBINIT;
        repeat (4) begin
            delay = int'(next_random() % 151);
            train_phase(ph, prev, delay);
            prev = ph;
            ph   = next_phase(ph);
        end
        check_value("link_active_o", link_active_o, 1);
    endtask

    // Bad parity, wrong phase and wrong opcode must all leave MBINIT in place
    task automatic bad_responses();
        logic [7:0] req_f;
        logic [7:0] bad [3];
        int         k;
        int         gap;
        req_f  = make_frame(OP_REQ, MBINIT);
        expect_frame(req_f, make_frame(OP_REQ, SBINIT));
        // Only the parity bit flipped, so the body is still a matching response
        bad[0] = make_frame(OP_RSP, MBINIT) ^ 8'h80;
        bad[1] = make_frame(OP_RSP, LINKINIT);
        bad[2] = make_frame(OP_REQ, MBINIT);
        for (k = 0; k < 3; k++) begin
            gap = int'(next_random() % 16);
            repeat (gap) @(posedge clk_100MHz);
            send_frame(bad[k]);
            repeat (20) @(posedge clk_100MHz);
            #1;
            check_value("ltsm_state_o", ltsm_state_o, MBINIT);
        end
        while (rx_frames.size() > 0) begin
            check_value("sb_frame", {24'd0, rx_frames.pop_front()}, {24'd0, req_f});
        end
        send_frame(make_frame(OP_RSP, MBINIT));
        wait_state(MBTRAIN, 30);
    endtask

    // Partner goes silent in MBTRAIN
    task automatic stall_to_error();
        expect_frame(make_frame(OP_REQ, MBTRAIN), make_frame(OP_REQ, MBINIT));
        wait_state(TRAINERROR, TIMEOUT_CYCLES + 100);
        expect_frame(make_frame(OP_ERR, TRAINERROR), make_frame(OP_REQ, MBTRAIN));
        wait_state(RESET, 50);
        repeat (150) @(posedge clk_100MHz);
        #1;
        check_value("frames after error", rx_frames.size(), 0);
        check_value("ltsm_state_o", ltsm_state_o, RESET);
    endtask

    initial begin
        int first;
        int i;
        reset      = 1'b1;
        enable_i   = 1'b0;
        start_lt_i = 1'b0;
        sb_clk_i   = 1'b0;
        sb_data_i  = 1'b0;
        fork
            decode_frames();
        join_none
        repeat (2) @(posedge clk_100MHz);
        #1;
        reset    = 1'b0;
        enable_i = 1'b1;

        first = error_count;
        for (i = 0; i < 200; i++) begin
            @(posedge clk_100MHz);
            #1;
            check_value("ltsm_state_o", ltsm_state_o, RESET);
            check_value("sb_clk_o", sb_clk_o, 0);
            check_value("sb_data_o", sb_data_o, 0);
            check_value("link_active_o", link_active_o, 0);
        end
        check_value("frames in RESET", rx_frames.size(), 0);
        end_test("idle in RESET", first);

        first = error_count;
        start_training();
        train_link();
        end_test("training to ACTIVE", first);

        first = error_count;
        apply_reset();
        start_training();
        train_phase(SBINIT, RESET, 140);
        end_test("request resent after retry window", first);

        first = error_count;
        bad_responses();
        end_test("bad responses ignored", first);

        first = error_count;
        stall_to_error();
        start_training();
        train_link();
        end_test("timeout, error frame and retraining", first);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== ltsm_top.f ====
+incdir+verification
source/ltsm_pkg.sv
source/sb_msg_if.sv
source/sb_frame_tx.sv
source/sb_frame_rx.sv
source/ltsm_timers.sv
source/ltsm_sequencer.sv
source/ltsm_top.sv
verification/ltsm_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = ltsm_tb
FILELIST = ltsm_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
